/* build.f */
s2mm_pkg.sv
s2mm_fifo.sv
s2mm_burst_planner.sv
s2mm_burst_writer.sv
s2mm_top.sv
s2mm_checker.sv
tb_s2mm.sv

/* run.sh */
#!/bin/sh
# Build and run the s2mm testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_s2mm \
   -f build.f -o sim_s2mm
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_s2mm > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Regression failed" "$LOG"; then
   exit 1
fi
exit 0

/* tb_s2mm.sv */
// ********************
// Testbench for s2mm_top, random stream source, AXI4 slave memory
// model and a reference model of the planned bursts
// ********************
`timescale 1ns/1ps
`default_nettype none

module tb_s2mm;

   localparam int ADDR_W       = 32;
   localparam int FIFO_AW      = 5;
   localparam int LEN_W        = 16;
   localparam int CLK_PERIOD   = 8;
   localparam int MEM_WORDS    = 2048;
   localparam int MAX_WORDS    = 300;
   localparam int N_TRANSFERS  = 13;
   // Worst case per word with heavy stalls and one-beat bursts
   localparam int CYC_PER_WORD = 30;
   localparam int WATCHDOG_CYC = N_TRANSFERS * (MAX_WORDS * CYC_PER_WORD + 100) + 200;
   localparam logic [s2mm_pkg::RESP_W-1:0] RESP_SLVERR = 2'b10;

   logic                            clk_i      = 1'b0;
   logic                            reset_i    = 1'b1;
   logic                            s_tvalid_i = 1'b0;
   logic [s2mm_pkg::DATA_W-1:0]     s_tdata_i  = '0;
   logic                            s_tready_o;
   logic                            start_i    = 1'b0;
   logic [ADDR_W-1:0]               addr_i     = '0;
   logic [LEN_W-1:0]                len_i      = '0;
   logic [FIFO_AW:0]                max_len_i  = '0;
   logic                            busy_o;
   logic                            error_o;
   logic                            awvalid_o;
   logic                            awready_i  = 1'b0;
   logic [ADDR_W-1:0]               awaddr_o;
   logic [s2mm_pkg::AXI_LEN_W-1:0]  awlen_o;
   logic [s2mm_pkg::SIZE_W-1:0]     awsize_o;
   logic [s2mm_pkg::BURST_W-1:0]    awburst_o;
   logic                            wvalid_o;
   logic                            wready_i   = 1'b0;
   logic [s2mm_pkg::DATA_W-1:0]     wdata_o;
   logic [s2mm_pkg::STRB_W-1:0]     wstrb_o;
   logic                            wlast_o;
   logic                            bvalid_i   = 1'b0;
   logic                            bready_o;
   logic [s2mm_pkg::RESP_W-1:0]     bresp_i    = s2mm_pkg::RESP_OKAY;

   int                              seed       = 65;
   string                           test_name  = "reset";
   logic                            fail_shown = 1'b0;
   logic                            run_done   = 1'b0;
   int                              aw_stall   = 0;
   int                              w_stall    = 0;
   int                              src_gap    = 0;
   int                              src_target = 0;
   int                              src_count  = 0;
   int                              err_burst  = -1;
   logic [s2mm_pkg::DATA_W-1:0]     sent_q [$];
   logic [s2mm_pkg::DATA_W-1:0]     mem [MEM_WORDS];
   logic                            written [MEM_WORDS];
   logic [ADDR_W-1:0]               exp_addr;
   logic [ADDR_W-1:0]               cur_addr;
   int                              exp_remain;
   int                              win_base;
   int                              win_len;
   int                              cur_beats;
   int                              beat_idx;
   int                              burst_idx;
   int                              wr_count;
   int                              b_wait;

   s2mm_top #(
      .ADDR_W (ADDR_W),
      .FIFO_AW(FIFO_AW),
      .LEN_W  (LEN_W)
   ) i_s2mm_top (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .s_tvalid_i(s_tvalid_i),
      .s_tdata_i (s_tdata_i),
      .s_tready_o(s_tready_o),
      .start_i   (start_i),
      .addr_i    (addr_i),
      .len_i     (len_i),
      .max_len_i (max_len_i),
      .busy_o    (busy_o),
      .error_o   (error_o),
      .awvalid_o (awvalid_o),
      .awready_i (awready_i),
      .awaddr_o  (awaddr_o),
      .awlen_o   (awlen_o),
      .awsize_o  (awsize_o),
      .awburst_o (awburst_o),
      .wvalid_o  (wvalid_o),
      .wready_i  (wready_i),
      .wdata_o   (wdata_o),
      .wstrb_o   (wstrb_o),
      .wlast_o   (wlast_o),
      .bvalid_i  (bvalid_i),
      .bready_o  (bready_o),
      .bresp_i   (bresp_i)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   task automatic check(input string what, input logic [63:0] exp_v, input logic [63:0] act_v);
      if (exp_v !== act_v) begin
         $display("error [%s] %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
         fail_shown = 1'b1;
         $display("Regression failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // Stream source, a word is held until the FIFO takes it
   always @(posedge clk_i) begin
      int taken;
      if (reset_i) begin
         s_tvalid_i <= 1'b0;
         src_count  <= 0;
      end else begin
         taken = src_count;
         if (s_tvalid_i && s_tready_o) begin
            sent_q.push_back(s_tdata_i);
            taken = src_count + 1;
         end
         src_count <= taken;
         if (!s_tvalid_i || s_tready_o) begin
            if (src_target > taken && rand_below(100) >= src_gap) begin
               s_tvalid_i <= 1'b1;
               s_tdata_i  <= $random(seed);
            end else begin
               s_tvalid_i <= 1'b0;
            end
         end
      end
   end

   // AXI4 slave memory with the expected burst sequence
   always @(posedge clk_i) begin
      int idx;
      int beats;
      int exp_beats;
      if (reset_i) begin
         awready_i  <= 1'b0;
         wready_i   <= 1'b0;
         bvalid_i   <= 1'b0;
         b_wait     <= 0;
         burst_idx  <= 0;
         wr_count   <= 0;
         exp_remain <= 0;
      end else begin
         awready_i <= rand_below(100) >= aw_stall;
         wready_i  <= rand_below(100) >= w_stall;
         if (start_i && !busy_o) begin
            exp_addr   <= addr_i;
            exp_remain <= int'(len_i);
            win_base   <= int'(addr_i >> s2mm_pkg::BYTE_SHIFT);
            win_len    <= int'(len_i);
            burst_idx  <= 0;
            wr_count   <= 0;
            for (int k = 0; k < int'(len_i); k++) begin
               written[int'(addr_i >> s2mm_pkg::BYTE_SHIFT) + k] <= 1'b0;
            end
         end
         if (awvalid_o && awready_i) begin
            beats     = int'(awlen_o) + 1;
            exp_beats = (exp_remain < int'(max_len_i)) ? exp_remain : int'(max_len_i);
            check("aw beats", exp_beats, beats);
            check("aw address", exp_addr, awaddr_o);
            check("aw size", s2mm_pkg::SIZE_4B, awsize_o);
            check("aw burst", s2mm_pkg::BURST_INCR, awburst_o);
            cur_addr   <= awaddr_o;
            cur_beats  <= beats;
            beat_idx   <= 0;
            exp_addr   <= exp_addr + (ADDR_W'(exp_beats) << s2mm_pkg::BYTE_SHIFT);
            exp_remain <= exp_remain - exp_beats;
         end
         if (b_wait != 0) begin
            b_wait <= b_wait - 1;
         end
         if (wvalid_o && wready_i) begin
            idx = int'(cur_addr >> s2mm_pkg::BYTE_SHIFT) + beat_idx;
            check("write inside transfer", 1, (idx >= win_base) && (idx < win_base + win_len));
            check("one write per word", 0, written[idx]);
            check("wstrb", {s2mm_pkg::STRB_W{1'b1}}, wstrb_o);
            check("wlast position", (beat_idx + 1 == cur_beats), wlast_o);
            mem[idx]     <= wdata_o;
            written[idx] <= 1'b1;
            beat_idx     <= beat_idx + 1;
            wr_count     <= wr_count + 1;
            if (wlast_o) begin
               b_wait <= 1 + rand_below(3);
            end
         end
         if (b_wait == 1) begin
            bvalid_i <= 1'b1;
            bresp_i  <= (burst_idx == err_burst) ? RESP_SLVERR : s2mm_pkg::RESP_OKAY;
         end
         if (bvalid_i && bready_o) begin
            check("beats before response", cur_beats, beat_idx);
            bvalid_i  <= 1'b0;
            bresp_i   <= s2mm_pkg::RESP_OKAY;
            burst_idx <= burst_idx + 1;
         end
      end
   end

   task automatic run_transfer(input int len, input int mx, input int err_at,
                               input logic exp_err);
      int                          base;
      int                          nb;
      logic [s2mm_pkg::DATA_W-1:0] word;
      base = rand_below(1024);
      nb   = (len + mx - 1) / mx;
      @(posedge clk_i);
      err_burst  <= err_at;
      addr_i     <= ADDR_W'(base) << s2mm_pkg::BYTE_SHIFT;
      len_i      <= LEN_W'(len);
      max_len_i  <= mx[FIFO_AW:0];
      start_i    <= 1'b1;
      src_target <= src_target + len;
      @(posedge clk_i);
      start_i <= 1'b0;
      @(posedge clk_i);
      check("busy after start", 1, busy_o);
      while (busy_o) begin
         @(posedge clk_i);
      end
      check("burst count", nb, burst_idx);
      check("words written", len, wr_count);
      check("words sent", len, sent_q.size());
      for (int i = 0; i < len; i++) begin
         word = sent_q.pop_front();
         check("memory word", word, mem[base + i]);
      end
      check("error flag", exp_err, error_o);
   endtask

   initial begin
      int len;
      int mx;
      repeat (8) begin
         @(posedge clk_i);
      end
      reset_i <= 1'b0;
      @(posedge clk_i);
      check("busy", 0, busy_o);
      check("error", 0, error_o);
      check("awvalid", 0, awvalid_o);
      check("wvalid", 0, wvalid_o);
      check("wlast", 0, wlast_o);
      check("bready", 0, bready_o);
      check("tready", 1, s_tready_o);

      test_name <= "zero_len";
      run_transfer(0, 4, -1, 1'b0);

      test_name <= "max_len_sweep";
      aw_stall  <= 10;
      w_stall   <= 10;
      src_gap   <= 20;
      run_transfer(1 + rand_below(MAX_WORDS), 1, -1, 1'b0);
      run_transfer(1 + rand_below(MAX_WORDS), 1 << FIFO_AW, -1, 1'b0);
      repeat (4) begin
         run_transfer(1 + rand_below(MAX_WORDS), 1 + rand_below(1 << FIFO_AW), -1, 1'b0);
      end

      // Heavy slave stalls and a bursty source
      test_name <= "backpressure";
      aw_stall  <= 70;
      w_stall   <= 70;
      src_gap   <= 60;
      repeat (4) begin
         run_transfer(1 + rand_below(MAX_WORDS), 1 + rand_below(1 << FIFO_AW), -1, 1'b0);
      end

      test_name <= "error_resp";
      aw_stall  <= 30;
      w_stall   <= 30;
      src_gap   <= 30;
      len = 1 + rand_below(MAX_WORDS);
      mx  = 1 + rand_below(1 << FIFO_AW);
      run_transfer(len, mx, rand_below((len + mx - 1) / mx), 1'b1);
      run_transfer(1 + rand_below(MAX_WORDS), 1 + rand_below(1 << FIFO_AW), -1, 1'b0);

      run_done = 1'b1;
      $display("Regression passed");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("timeout: transfers did not finish within %0d cycles", WATCHDOG_CYC);
      fail_shown = 1'b1;
      $display("Regression failed");
      $fatal(1, "watchdog expired");
   end

   // A stop from a bound assertion ends here without a verdict yet
   final begin
      if (!run_done && !fail_shown) begin
         $display("Regression failed");
      end
   end

endmodule

`default_nettype wire

/* s2mm_checker.sv */
// ********************
// Handshake assertions for s2mm_top, attached with bind
// ********************
`timescale 1ns/1ps
`default_nettype none

module s2mm_checker #(
   parameter int ADDR_W = 32
) (
   input wire                                clk_i,
   input wire                                reset_i,
   input wire                                s_tvalid_i,
   input wire                                s_tready_i,
   input wire  [s2mm_pkg::DATA_W-1:0]        s_tdata_i,
   input wire                                awvalid_i,
   input wire                                awready_i,
   input wire  [ADDR_W-1:0]                  awaddr_i,
   input wire  [s2mm_pkg::AXI_LEN_W-1:0]     awlen_i,
   input wire                                wvalid_i,
   input wire                                wready_i,
   input wire  [s2mm_pkg::DATA_W-1:0]        wdata_i,
   input wire                                wlast_i,
   input wire                                bvalid_i,
   input wire                                bready_i,
   input wire                                busy_i
);

   logic                          burst_open_q;
   logic [s2mm_pkg::AXI_LEN_W:0]  beats_left_q;

   // Open from AW acceptance until its B response
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         burst_open_q <= 1'b0;
      end else if (awvalid_i && awready_i) begin
         burst_open_q <= 1'b1;
      end else if (bvalid_i && bready_i) begin
         burst_open_q <= 1'b0;
      end
   end

   // Beats still owed to the accepted AW
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         beats_left_q <= '0;
      end else if (awvalid_i && awready_i) begin
         beats_left_q <= {1'b0, awlen_i} + 1'b1;
      end else if (wvalid_i && wready_i) begin
         beats_left_q <= beats_left_q - 1'b1;
      end
   end

   aw_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awlen_i))
      else $error("AW payload changed while stalled");

   w_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wlast_i))
      else $error("W payload changed while stalled");

   s_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      s_tvalid_i && !s_tready_i |=> s_tvalid_i && $stable(s_tdata_i))
      else $error("stream word changed while stalled");

   wlast_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      wlast_i |-> wvalid_i && beats_left_q == 1)
      else $error("wlast without wvalid or off the last beat");

   busy_after_b: assert property (@(posedge clk_i) disable iff (reset_i)
      $fell(busy_i) |-> !burst_open_q)
      else $error("busy dropped before the last B response");

endmodule

bind s2mm_top s2mm_checker #(
   .ADDR_W(ADDR_W)
) i_checker (
   .clk_i     (clk_i),
   .reset_i   (reset_i),
   .s_tvalid_i(s_tvalid_i),
   .s_tready_i(s_tready_o),
   .s_tdata_i (s_tdata_i),
   .awvalid_i (awvalid_o),
   .awready_i (awready_i),
   .awaddr_i  (awaddr_o),
   .awlen_i   (awlen_o),
   .wvalid_i  (wvalid_o),
   .wready_i  (wready_i),
   .wdata_i   (wdata_o),
   .wlast_i   (wlast_o),
   .bvalid_i  (bvalid_i),
   .bready_i  (bready_o),
   .busy_i    (busy_o)
);

`default_nettype wire

/* s2mm_top.sv */
// ********************
// Stream to memory write engine, FIFO plus burst planner and writer
// ********************
`timescale 1ns/1ps
`default_nettype none

module s2mm_top #(
   parameter int ADDR_W  = 32,
   parameter int FIFO_AW = 5,
   parameter int LEN_W   = 16
) (
   input  wire                             clk_i,
   input  wire                             reset_i,
   // Stream slave
   input  wire                             s_tvalid_i,
   input  wire  [s2mm_pkg::DATA_W-1:0]     s_tdata_i,
   output logic                            s_tready_o,
   // Control
   input  wire                             start_i,
   input  wire  [ADDR_W-1:0]               addr_i,
   input  wire  [LEN_W-1:0]                len_i,
   input  wire  [FIFO_AW:0]                max_len_i,
   output logic                            busy_o,
   output logic                            error_o,
   // AXI4 write master
   output logic                            awvalid_o,
   input  wire                             awready_i,
   output logic [ADDR_W-1:0]               awaddr_o,
   output logic [s2mm_pkg::AXI_LEN_W-1:0]  awlen_o,
   output logic [s2mm_pkg::SIZE_W-1:0]     awsize_o,
   output logic [s2mm_pkg::BURST_W-1:0]    awburst_o,
   output logic                            wvalid_o,
   input  wire                             wready_i,
   output logic [s2mm_pkg::DATA_W-1:0]     wdata_o,
   output logic [s2mm_pkg::STRB_W-1:0]     wstrb_o,
   output logic                            wlast_o,
   input  wire                             bvalid_i,
   output logic                            bready_o,
   input  wire  [s2mm_pkg::RESP_W-1:0]     bresp_i
);

   logic                            fifo_full;
   logic                            fifo_empty;
   logic                            fifo_rd;
   logic [s2mm_pkg::DATA_W-1:0]     fifo_data;
   logic [FIFO_AW:0]                fifo_level;
   logic                            cmd_valid;
   logic [ADDR_W-1:0]               cmd_addr;
   logic [s2mm_pkg::CMD_LEN_W-1:0]  cmd_len;
   logic                            wr_busy;
   logic                            start_accept;

   assign s_tready_o   = !fifo_full;
   // Start only counts while no transfer is running
   assign start_accept = start_i && !busy_o;

   s2mm_fifo #(
      .DATA_W (s2mm_pkg::DATA_W),
      .FIFO_AW(FIFO_AW)
   ) i_fifo (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .wr_en_i  (s_tvalid_i && s_tready_o),
      .wr_data_i(s_tdata_i),
      .full_o   (fifo_full),
      .rd_en_i  (fifo_rd),
      .rd_data_o(fifo_data),
      .empty_o  (fifo_empty),
      .level_o  (fifo_level)
   );

   s2mm_burst_planner #(
      .ADDR_W (ADDR_W),
      .FIFO_AW(FIFO_AW),
      .LEN_W  (LEN_W)
   ) i_planner (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .start_i    (start_i),
      .addr_i     (addr_i),
      .len_i      (len_i),
      .max_len_i  (max_len_i),
      .level_i    (fifo_level),
      .wr_busy_i  (wr_busy),
      .cmd_valid_o(cmd_valid),
      .cmd_addr_o (cmd_addr),
      .cmd_len_o  (cmd_len),
      .busy_o     (busy_o)
   );

   s2mm_burst_writer #(
      .ADDR_W(ADDR_W)
   ) i_writer (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cmd_valid_i (cmd_valid),
      .cmd_addr_i  (cmd_addr),
      .cmd_len_i   (cmd_len),
      .busy_o      (wr_busy),
      .fifo_empty_i(fifo_empty),
      .fifo_data_i (fifo_data),
      .fifo_rd_o   (fifo_rd),
      .start_i     (start_accept),
      .error_o     (error_o),
      .awvalid_o   (awvalid_o),
      .awready_i   (awready_i),
      .awaddr_o    (awaddr_o),
      .awlen_o     (awlen_o),
      .awsize_o    (awsize_o),
      .awburst_o   (awburst_o),
      .wvalid_o    (wvalid_o),
      .wready_i    (wready_i),
      .wdata_o     (wdata_o),
      .wstrb_o     (wstrb_o),
      .wlast_o     (wlast_o),
      .bvalid_i    (bvalid_i),
      .bready_o    (bready_o),
      .bresp_i     (bresp_i)
   );

endmodule

`default_nettype wire

/* s2mm_burst_writer.sv */
// ********************
// AXI4 write master, one AW, its W beats from the FIFO, then B
// Takes one planned burst at a time
// ********************
`timescale 1ns/1ps
`default_nettype none

module s2mm_burst_writer #(
   parameter int ADDR_W = 32
) (
   input  wire                                clk_i,
   input  wire                                reset_i,
   // Burst command
   input  wire                                cmd_valid_i,
   input  wire  [ADDR_W-1:0]                  cmd_addr_i,
   input  wire  [s2mm_pkg::CMD_LEN_W-1:0]     cmd_len_i,
   output logic                               busy_o,
   // FIFO read side
   input  wire                                fifo_empty_i,
   input  wire  [s2mm_pkg::DATA_W-1:0]        fifo_data_i,
   output logic                               fifo_rd_o,
   // Error flag
   input  wire                                start_i,
   output logic                               error_o,
   // AW channel
   output logic                               awvalid_o,
   input  wire                                awready_i,
   output logic [ADDR_W-1:0]                  awaddr_o,
   output logic [s2mm_pkg::AXI_LEN_W-1:0]     awlen_o,
   output logic [s2mm_pkg::SIZE_W-1:0]        awsize_o,
   output logic [s2mm_pkg::BURST_W-1:0]       awburst_o,
   // W channel
   output logic                               wvalid_o,
   input  wire                                wready_i,
   output logic [s2mm_pkg::DATA_W-1:0]        wdata_o,
   output logic [s2mm_pkg::STRB_W-1:0]        wstrb_o,
   output logic                               wlast_o,
   // B channel
   input  wire                                bvalid_i,
   output logic                               bready_o,
   input  wire  [s2mm_pkg::RESP_W-1:0]        bresp_i
);

   localparam int CMD_W = s2mm_pkg::CMD_LEN_W;

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_ADDR = 2'd1;
   localparam logic [1:0] ST_DATA = 2'd2;
   localparam logic [1:0] ST_RESP = 2'd3;

   logic [1:0]        state_q;
   logic [ADDR_W-1:0] addr_q;
   logic [CMD_W-1:0]  beats_q;
   logic              error_q;
   logic              last_beat;
   logic              aw_fire;
   logic              w_fire;
   logic              b_fire;

   assign last_beat = (beats_q == CMD_W'(1));
   assign aw_fire   = awvalid_o && awready_i;
   assign w_fire    = wvalid_o && wready_i;
   assign b_fire    = bvalid_i && bready_o;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (cmd_valid_i) begin
                  state_q <= ST_ADDR;
               end
            end
            ST_ADDR: begin
               if (aw_fire) begin
                  state_q <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (w_fire && last_beat) begin
                  state_q <= ST_RESP;
               end
            end
            default: begin
               if (b_fire) begin
                  state_q <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // Counter holds the burst length through AW, then counts down beats
   always_ff @(posedge clk_i) begin
      if (state_q == ST_IDLE && cmd_valid_i) begin
         addr_q  <= cmd_addr_i;
         beats_q <= cmd_len_i;
      end else if (w_fire) begin
         beats_q <= beats_q - 1'b1;
      end
   end

   // Sticky until the next accepted transfer start
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         error_q <= 1'b0;
      end else if (start_i) begin
         error_q <= 1'b0;
      end else if (b_fire && bresp_i != s2mm_pkg::RESP_OKAY) begin
         error_q <= 1'b1;
      end
   end

   assign busy_o    = (state_q != ST_IDLE);
   assign error_o   = error_q;
   assign awvalid_o = (state_q == ST_ADDR);
   assign awaddr_o  = addr_q;
   assign awlen_o   = s2mm_pkg::AXI_LEN_W'(beats_q - 1'b1);
   assign awsize_o  = s2mm_pkg::SIZE_4B;
   assign awburst_o = s2mm_pkg::BURST_INCR;
   assign wvalid_o  = (state_q == ST_DATA) && !fifo_empty_i;
   assign wdata_o   = fifo_data_i;
   assign wstrb_o   = '1;
   assign wlast_o   = wvalid_o && last_beat;
   assign fifo_rd_o = w_fire;
   assign bready_o  = (state_q == ST_RESP);

endmodule

`default_nettype wire

/* s2mm_burst_planner.sv */
// ********************
// Splits a transfer into bursts that the FIFO already holds
// Issues one command per burst to the writer
// ********************
`timescale 1ns/1ps
`default_nettype none

module s2mm_burst_planner #(
   parameter int ADDR_W  = 32,
   parameter int FIFO_AW = 5,
   parameter int LEN_W   = 16
) (
   input  wire                              clk_i,
   input  wire                              reset_i,
   // Transfer request
   input  wire                              start_i,
   input  wire  [ADDR_W-1:0]                addr_i,
   input  wire  [LEN_W-1:0]                 len_i,
   input  wire  [FIFO_AW:0]                 max_len_i,
   // FIFO word count
   input  wire  [FIFO_AW:0]                 level_i,
   // Writer handshake
   input  wire                              wr_busy_i,
   output logic                             cmd_valid_o,
   output logic [ADDR_W-1:0]                cmd_addr_o,
   output logic [s2mm_pkg::CMD_LEN_W-1:0]   cmd_len_o,
   output logic                             busy_o
);

   localparam int CMD_W = s2mm_pkg::CMD_LEN_W;
   localparam int CMP_W = (LEN_W > FIFO_AW + 1) ? LEN_W : FIFO_AW + 1;

   localparam logic ST_IDLE = 1'b0;
   localparam logic ST_WAIT = 1'b1;

   logic              state_q;
   logic [LEN_W-1:0]  remain_q;
   logic [ADDR_W-1:0] addr_q;

   logic [CMP_W-1:0]  remain_x;
   logic [CMP_W-1:0]  max_x;
   logic [CMP_W-1:0]  level_x;
   logic [CMP_W-1:0]  burst_x;
   logic              start_ok;
   logic              issue;
   logic              done;

   always_comb begin
      remain_x = CMP_W'(remain_q);
      max_x    = CMP_W'(max_len_i);
      level_x  = CMP_W'(level_i);
      // Lesser of what is left and the maximum burst
      burst_x  = (remain_x <= max_x) ? remain_x : max_x;
      start_ok = (state_q == ST_IDLE) && start_i;
      issue    = (state_q == ST_WAIT) && !wr_busy_i && (remain_q != '0) &&
                 (level_x >= burst_x);
      done     = (state_q == ST_WAIT) && !wr_busy_i && (remain_q == '0);
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= ST_IDLE;
      end else if (start_ok) begin
         state_q <= ST_WAIT;
      end else if (done) begin
         state_q <= ST_IDLE;
      end
   end

   // Remaining words and next burst address
   always_ff @(posedge clk_i) begin
      if (start_ok) begin
         remain_q <= len_i;
         addr_q   <= addr_i;
      end else if (issue) begin
         remain_q <= remain_q - LEN_W'(burst_x);
         addr_q   <= addr_q + (ADDR_W'(burst_x) << s2mm_pkg::BYTE_SHIFT);
      end
   end

   assign cmd_valid_o = issue;
   assign cmd_addr_o  = addr_q;
   assign cmd_len_o   = CMD_W'(burst_x);
   assign busy_o      = (state_q == ST_WAIT);

endmodule

`default_nettype wire

/* s2mm_fifo.sv */
// ********************
// Synchronous first-word-fall-through FIFO with a word count
// Buffers the incoming stream ahead of the AXI writer
// ********************
`timescale 1ns/1ps
`default_nettype none

module s2mm_fifo #(
   parameter int DATA_W  = 32,
   parameter int FIFO_AW = 5
) (
   input  wire                clk_i,
   input  wire                reset_i,
   // Write side
   input  wire                wr_en_i,
   input  wire  [DATA_W-1:0]  wr_data_i,
   output logic               full_o,
   // Read side
   input  wire                rd_en_i,
   output logic [DATA_W-1:0]  rd_data_o,
   output logic               empty_o,
   output logic [FIFO_AW:0]   level_o
);

   localparam int DEPTH = 1 << FIFO_AW;

   logic [DATA_W-1:0]  mem [DEPTH];
   logic [FIFO_AW-1:0] wr_ptr_q;
   logic [FIFO_AW-1:0] rd_ptr_q;
   logic [FIFO_AW:0]   level_q;
   logic               do_wr;
   logic               do_rd;

   assign do_wr = wr_en_i && !full_o;
   assign do_rd = rd_en_i && !empty_o;

   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wr_ptr_q] <= wr_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_rd) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         if (do_wr && !do_rd) begin
            level_q <= level_q + 1'b1;
         end else if (do_rd && !do_wr) begin
            level_q <= level_q - 1'b1;
         end
      end
   end

   // Level never exceeds DEPTH, so its top bit means full
   assign full_o    = level_q[FIFO_AW];
   assign empty_o   = (level_q == '0);
   assign level_o   = level_q;
   assign rd_data_o = mem[rd_ptr_q];

endmodule

`default_nettype wire

/* s2mm_pkg.sv */
// ********************
// Widths and AXI4 encodings shared by the s2mm write engine
// Referenced by scoped name, never imported
// ********************
`default_nettype none

package s2mm_pkg;

   // Stream and AXI data path
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // log2 of bytes per beat, used for address steps
   localparam int BYTE_SHIFT = 2;

   // AXI4 write channel field widths
   localparam int AXI_LEN_W = 8;
   localparam int SIZE_W    = 3;
   localparam int BURST_W   = 2;
   localparam int RESP_W    = 2;

   // Burst length in beats, one bit wider than awlen
   localparam int CMD_LEN_W = AXI_LEN_W + 1;

   // Encodings
   localparam logic [SIZE_W-1:0]  SIZE_4B    = 3'b010;
   localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;
   localparam logic [RESP_W-1:0]  RESP_OKAY  = 2'b00;

endpackage

`default_nettype wire
